//--- exec_stage.f
+incdir+source
source/exec_pkg.sv
source/alu_unit.sv
source/mult_unit.sv
source/cdb_arbiter.sv
source/exec_stage.sv
testbench/exec_stage_props.sv
testbench/exec_stage_tb.sv

//--- Makefile
TOP := exec_stage_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f exec_stage.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

//--- testbench/exec_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module exec_stage_tb;

    import exec_pkg::*;

    localparam int ALU_ROUNDS  = 20;
    localparam int BR_ROUNDS   = 12;
    localparam int MULT_ROUNDS = 16;
    localparam int BURST       = 24;
    localparam int CONTEND     = 16;
    localparam int DRAIN_MAX   = 200;
    // Stimulus cycles summed over all tests, drains included
    localparam int TOTAL_CYCLES = 10 + 10 * ALU_ROUNDS + 8 * BR_ROUNDS
                                + 4 * (MULT_ROUNDS + 5) + BURST + CONTEND
                                + 6 * (`EXEC_MULT_STAGES + 10);

    logic           clock;
    logic           reset;
    alu_packet_t    alu_issue;
    mult_packet_t   mult_issue;
    cdb_packet_t    cdb;
    branch_packet_t branch_resolve;
    logic           mult_free;

    int          seed = 69;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    cdb_packet_t exp_alu;
    branch_packet_t exp_br;
    cdb_packet_t mult_head;
    cdb_packet_t mult_q[$];

    exec_stage u_exec_stage (
        .clock          (clock),
        .reset          (reset),
        .alu_issue      (alu_issue),
        .mult_issue     (mult_issue),
        .cdb            (cdb),
        .branch_resolve (branch_resolve),
        .mult_free      (mult_free)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic data_t alu_value(alu_op_e op, data_t a, data_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            default:  return {31'b0, a < b};
        endcase
    endfunction

    function automatic cdb_packet_t predict_alu(alu_packet_t p);
        cdb_packet_t r;
        logic        link;
        link     = p.branch_op == BR_JAL || p.branch_op == BR_JALR;
        r.valid  = p.valid && (p.branch_op == BR_NONE || link);
        r.result = link ? p.pc + 32'd4 : alu_value(p.alu_op, p.opa, p.opb);
        r.dest   = p.dest;
        return r;
    endfunction

    function automatic branch_packet_t predict_branch(alu_packet_t p);
        branch_packet_t r;
        data_t          sum;
        sum    = p.opa + p.offset;
        r.valid = p.valid && p.branch_op != BR_NONE;
        case (p.branch_op)
            BR_JAL, BR_JALR: r.take = 1'b1;
            BR_BEQ:  r.take = p.opa == p.opb;
            BR_BNE:  r.take = p.opa != p.opb;
            BR_BLT:  r.take = $signed(p.opa) < $signed(p.opb);
            BR_BGE:  r.take = !($signed(p.opa) < $signed(p.opb));
            BR_BLTU: r.take = p.opa < p.opb;
            default: r.take = !(p.opa < p.opb);
        endcase
        r.target = (p.branch_op == BR_JALR) ? (sum & ~32'd1) : p.pc + p.offset;
        return r;
    endfunction

    // 64-bit reference product, operands extended by kind
    function automatic cdb_packet_t predict_mult(mult_packet_t p);
        cdb_packet_t r;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] prod;
        a = {32'b0, p.rs1_value};
        b = {32'b0, p.rs2_value};
        if (p.mult_op == MULT_MULH || p.mult_op == MULT_MULHSU) begin
            a = {{32{p.rs1_value[31]}}, p.rs1_value};
        end
        if (p.mult_op == MULT_MULH) begin
            b = {{32{p.rs2_value[31]}}, p.rs2_value};
        end
        prod     = a * b;
        r.valid  = 1'b1;
        r.result = (p.mult_op == MULT_MUL) ? prod[31:0] : prod[63:32];
        r.dest   = p.dest;
        return r;
    endfunction

    // Reference model, updated on the same edges as the DUT
    always @(posedge clock) begin
        if (reset) begin
            exp_alu   <= '0;
            exp_br    <= '0;
            mult_head <= '0;
            mult_q.delete();
        end else begin
            exp_alu <= predict_alu(alu_issue);
            exp_br  <= predict_branch(alu_issue);
            if (cdb.valid && !exp_alu.valid && mult_q.size() > 0) begin
                void'(mult_q.pop_front());
            end
            if (mult_issue.valid && mult_free) begin
                mult_q.push_back(predict_mult(mult_issue));
            end
            mult_head <= (mult_q.size() > 0) ? mult_q[0] : '0;
        end
    end

    alu_result_check: assert property (
        @(posedge clock) disable iff (reset)
        exp_alu.valid |-> cdb.valid && cdb.result == exp_alu.result && cdb.dest == exp_alu.dest
    ) else begin
        errors++;
        $display("Error at %0t ns: ALU result wrong, expected %h for p%0d, got %h",
                 $time, $sampled(exp_alu.result), $sampled(exp_alu.dest), $sampled(cdb.result));
    end

    mult_result_check: assert property (
        @(posedge clock) disable iff (reset)
        cdb.valid && !exp_alu.valid |->
            mult_head.valid && cdb.result == mult_head.result && cdb.dest == mult_head.dest
    ) else begin
        errors++;
        $display("Error at %0t ns: multiply result wrong, expected %h for p%0d, got %h",
                 $time, $sampled(mult_head.result), $sampled(mult_head.dest),
                 $sampled(cdb.result));
    end

    branch_check: assert property (
        @(posedge clock) disable iff (reset)
        branch_resolve.valid == exp_br.valid &&
            (!exp_br.valid || (branch_resolve.take == exp_br.take &&
                               branch_resolve.target == exp_br.target))
    ) else begin
        errors++;
        $display("Error at %0t ns: branch resolution wrong, expected take %b target %h",
                 $time, $sampled(exp_br.take), $sampled(exp_br.target));
    end

    reset_state_check: assert property (
        @(posedge clock)
        $fell(reset) |-> !cdb.valid && !branch_resolve.valid && mult_free
    ) else begin
        errors++;
        $display("Error at %0t ns: stage not idle right after reset", $time);
    end

    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    task automatic send_alu(alu_op_e op, branch_op_e br, data_t a, data_t b, int dest);
        alu_issue.valid     = 1'b1;
        alu_issue.opa       = a;
        alu_issue.opb       = b;
        alu_issue.pc        = $random(seed) & ~32'd3;
        alu_issue.offset    = $random(seed);
        alu_issue.alu_op    = op;
        alu_issue.branch_op = br;
        alu_issue.dest      = preg_t'(dest);
        tick();
        alu_issue.valid = 1'b0;
    endtask

    task automatic send_mult(mult_op_e op, data_t a, data_t b, int dest);
        while (!mult_free) begin
            tick();
        end
        mult_issue.valid     = 1'b1;
        mult_issue.rs1_value = a;
        mult_issue.rs2_value = b;
        mult_issue.mult_op   = op;
        mult_issue.dest      = preg_t'(dest);
        tick();
        mult_issue.valid = 1'b0;
    endtask

    // Waits for every outstanding multiply to reach the CDB
    task automatic drain();
        int n;
        n = 0;
        while ((mult_q.size() > 0 || mult_head.valid) && n < DRAIN_MAX) begin
            tick();
            n++;
        end
        if (n == DRAIN_MAX) begin
            errors++;
            $display("Multiplier results never came out on the CDB");
        end
        tick();
        tick();
    endtask

    task automatic end_test(string name, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int          e;
        int          low_cycles;
        data_t       a;
        data_t       b;
        data_t       corner [5];
        alu_packet_t stream;

        corner[0] = 32'h8000_0000;
        corner[1] = 32'hffff_ffff;
        corner[2] = 32'h7fff_ffff;
        corner[3] = 32'h0000_0001;
        corner[4] = 32'h0000_0000;
        reset      = 1'b1;
        alu_issue  = '0;
        mult_issue = '0;
        repeat (10) tick();
        reset = 1'b0;

        e = errors;
        repeat (3) tick();
        end_test("reset", e);

        e = errors;
        for (int op = 0; op < 10; op++) begin
            for (int r = 0; r < ALU_ROUNDS; r++) begin
                send_alu(alu_op_e'(op), BR_NONE, $random(seed), $random(seed), r + 1);
            end
        end
        tick();
        end_test("alu ops", e);

        e = errors;
        for (int k = 1; k < 9; k++) begin
            for (int r = 0; r < BR_ROUNDS; r++) begin
                a = $random(seed);
                b = (r % 3 == 0) ? a : $random(seed);
                send_alu(ALU_ADD, branch_op_e'(k), a, b, r + 2);
            end
        end
        tick();
        end_test("branches", e);

        e = errors;
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < 5; i++) begin
                send_mult(mult_op_e'(op), corner[i], corner[(i + 4) % 5], i + 3);
            end
            for (int r = 0; r < MULT_ROUNDS; r++) begin
                send_mult(mult_op_e'(op), $random(seed), $random(seed), r + 10);
            end
        end
        drain();
        end_test("multiply kinds", e);

        e = errors;
        for (int r = 0; r < BURST; r++) begin
            send_mult(mult_op_e'(r % 4), $random(seed), $random(seed), r + 20);
        end
        drain();
        end_test("multiply burst", e);

        // ALU result every cycle while multiplies go in
        e = errors;
        low_cycles = 0;
        for (int c = 0; c < CONTEND; c++) begin
            stream.valid     = 1'b1;
            stream.opa       = $random(seed);
            stream.opb       = $random(seed);
            stream.pc        = '0;
            stream.offset    = '0;
            stream.alu_op    = ALU_XOR;
            stream.branch_op = BR_NONE;
            stream.dest      = preg_t'(c);
            alu_issue        = stream;
            mult_issue.valid = c < 6 && mult_free;
            mult_issue.rs1_value = $random(seed);
            mult_issue.rs2_value = $random(seed);
            mult_issue.mult_op   = mult_op_e'(c % 4);
            mult_issue.dest      = preg_t'(c + 40);
            if (!mult_free) begin
                low_cycles++;
            end
            tick();
        end
        alu_issue.valid  = 1'b0;
        mult_issue.valid = 1'b0;
        drain();
        if (low_cycles == 0) begin
            errors++;
            $display("mult_free never fell while the ALU held the CDB");
        end
        end_test("cdb contention", e);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((TOTAL_CYCLES * 3 + 500) * 4);
        $display("Run did not finish in time, the watchdog stopped it");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/exec_stage_props.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_props (
    input wire logic                     clock,
    input wire logic                     reset,
    input wire exec_pkg::cdb_packet_t    cdb,
    input wire exec_pkg::branch_packet_t branch_resolve,
    input wire exec_pkg::cdb_packet_t    alu_done,
    input wire exec_pkg::cdb_packet_t    mult_done,
    input wire logic                     mult_free
);

    import exec_pkg::*;

    // Bus strobe must always be a known level
    cdb_valid_known: assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown(cdb.valid)
    ) else $error("cdb.valid is unknown");

    // Freeze exactly while a finished product waits behind an ALU result
    mult_free_tracks_wait: assert property (
        @(posedge clock) disable iff (reset)
        !mult_free == (mult_done.valid && alu_done.valid)
    ) else $error("mult_free does not match a waiting multiplier result");

    // Reset clears all strobes
    reset_clears_valids: assert property (
        @(posedge clock)
        reset |=> !cdb.valid && !branch_resolve.valid && !mult_done.valid && mult_free
    ) else $error("a valid strobe survived reset");

endmodule

bind exec_stage exec_stage_props u_exec_stage_props (.*);

`default_nettype wire

//--- source/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  logic                     clock,
    input  logic                     reset,
    input  exec_pkg::alu_packet_t    alu_issue,
    input  exec_pkg::mult_packet_t   mult_issue,
    output exec_pkg::cdb_packet_t    cdb,
    output exec_pkg::branch_packet_t branch_resolve,
    output logic                     mult_free
);

    import exec_pkg::*;

    cdb_packet_t alu_done;
    cdb_packet_t mult_done;
    logic        mult_grant;

    // Single cycle integer and branch unit
    alu_unit u_alu_unit (
        .clock   (clock),
        .reset   (reset),
        .issue   (alu_issue),
        .done    (alu_done),
        .resolve (branch_resolve)
    );

    // Pipelined multiplier, held back by the arbiter
    mult_unit u_mult_unit (
        .clock (clock),
        .reset (reset),
        .issue (mult_issue),
        .grant (mult_grant),
        .done  (mult_done),
        .free  (mult_free)
    );

    cdb_arbiter u_cdb_arbiter (
        .alu_done   (alu_done),
        .mult_done  (mult_done),
        .mult_grant (mult_grant),
        .cdb        (cdb)
    );

endmodule

`default_nettype wire

//--- source/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
    input  exec_pkg::cdb_packet_t alu_done,
    input  exec_pkg::cdb_packet_t mult_done,
    output logic                  mult_grant,
    output exec_pkg::cdb_packet_t cdb
);

    // ALU has fixed priority since its latency cannot stretch
    assign mult_grant = mult_done.valid && !alu_done.valid;

    always_comb begin
        if (alu_done.valid) begin
            cdb = alu_done;
        end else begin
            // Multiplier result, or an idle bus when it has none
            cdb = mult_done;
        end
    end

endmodule

`default_nettype wire

//--- source/mult_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module mult_unit (
    input  logic                   clock,
    input  logic                   reset,
    input  exec_pkg::mult_packet_t issue,
    input  logic                   grant,
    output exec_pkg::cdb_packet_t  done,
    output logic                   free
);

    import exec_pkg::*;

    localparam int STAGES = `EXEC_MULT_STAGES;
    localparam int PROD_W = 2 * `EXEC_XLEN;
    // Multiplier bits consumed per stage, last chunk zero padded
    localparam int CHUNK  = (PROD_W + STAGES - 1) / STAGES;
    localparam int PAD_W  = STAGES * CHUNK;

    typedef logic [PROD_W-1:0] prod_t;

    typedef struct packed {
        logic             high;
        preg_t            dest;
        prod_t            a_ext;
        logic [PAD_W-1:0] b_ext;
        prod_t            psum;
    } stage_t;

    logic [STAGES-1:0] valid_q;
    stage_t            stage_q [STAGES];
    stage_t            first;
    logic              a_signed;
    logic              b_signed;
    logic              stall;

    // Product of a with one chunk of b, shifted into place
    function automatic prod_t partial(prod_t a, logic [PAD_W-1:0] b, int k);
        prod_t chunk;
        chunk = prod_t'(b[k*CHUNK +: CHUNK]);
        return (a * chunk) << (k * CHUNK);
    endfunction

    function automatic stage_t advance(stage_t s, int k);
        stage_t n;
        n      = s;
        n.psum = s.psum + partial(s.a_ext, s.b_ext, k);
        return n;
    endfunction

    // Operand extension by kind
    always_comb begin
        case (issue.mult_op)
            MULT_MULH:   {a_signed, b_signed} = 2'b11;
            MULT_MULHSU: {a_signed, b_signed} = 2'b10;
            default:     {a_signed, b_signed} = 2'b00;
        endcase
    end

    always_comb begin
        first.high  = issue.mult_op != MULT_MUL;
        first.dest  = issue.dest;
        first.a_ext = {{`EXEC_XLEN{a_signed & issue.rs1_value[`EXEC_XLEN-1]}},
                       issue.rs1_value};
        first.b_ext = PAD_W'({{`EXEC_XLEN{b_signed & issue.rs2_value[`EXEC_XLEN-1]}},
                              issue.rs2_value});
        first.psum  = partial(first.a_ext, first.b_ext, 0);
    end

    // Whole pipeline holds while the tail waits for the bus
    assign stall = valid_q[STAGES-1] && !grant;
    assign free  = !stall;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else if (!stall) begin
            valid_q <= {valid_q[STAGES-2:0], issue.valid};
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            stage_q[0] <= first;
            for (int k = 1; k < STAGES; k++) begin
                stage_q[k] <= advance(stage_q[k-1], k);
            end
        end
    end

    assign done.valid  = valid_q[STAGES-1];
    assign done.dest   = stage_q[STAGES-1].dest;
    assign done.result = stage_q[STAGES-1].high ? stage_q[STAGES-1].psum[PROD_W-1:`EXEC_XLEN]
                                                : stage_q[STAGES-1].psum[`EXEC_XLEN-1:0];

endmodule

`default_nettype wire

//--- source/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module alu_unit (
    input  logic                    clock,
    input  logic                    reset,
    input  exec_pkg::alu_packet_t   issue,
    output exec_pkg::cdb_packet_t   done,
    output exec_pkg::branch_packet_t resolve
);

    import exec_pkg::*;

    localparam int SHAMT_W = $clog2(`EXEC_XLEN);

    data_t               alu_result;
    data_t               jalr_sum;
    data_t               target;
    logic                take;
    logic                is_branch;
    logic                is_link;
    logic [SHAMT_W-1:0]  shamt;
    cdb_packet_t         done_next;
    branch_packet_t      resolve_next;

    assign shamt = issue.opb[SHAMT_W-1:0];

    always_comb begin
        case (issue.alu_op)
            ALU_ADD:  alu_result = issue.opa + issue.opb;
            ALU_SUB:  alu_result = issue.opa - issue.opb;
            ALU_AND:  alu_result = issue.opa & issue.opb;
            ALU_OR:   alu_result = issue.opa | issue.opb;
            ALU_XOR:  alu_result = issue.opa ^ issue.opb;
            ALU_SLL:  alu_result = issue.opa << shamt;
            ALU_SRL:  alu_result = issue.opa >> shamt;
            ALU_SRA:  alu_result = data_t'($signed(issue.opa) >>> shamt);
            ALU_SLT:  alu_result = data_t'($signed(issue.opa) < $signed(issue.opb));
            ALU_SLTU: alu_result = data_t'(issue.opa < issue.opb);
            default:  alu_result = issue.opa + issue.opb;
        endcase
    end

    // Branch condition, jumps always taken
    always_comb begin
        case (issue.branch_op)
            BR_JAL, BR_JALR: take = 1'b1;
            BR_BEQ:  take = issue.opa == issue.opb;
            BR_BNE:  take = issue.opa != issue.opb;
            BR_BLT:  take = $signed(issue.opa) < $signed(issue.opb);
            BR_BGE:  take = $signed(issue.opa) >= $signed(issue.opb);
            BR_BLTU: take = issue.opa < issue.opb;
            BR_BGEU: take = issue.opa >= issue.opb;
            default: take = 1'b0;
        endcase
    end

    assign is_branch = issue.branch_op != BR_NONE;
    assign is_link   = (issue.branch_op == BR_JAL) || (issue.branch_op == BR_JALR);

    // JALR target has bit 0 cleared
    assign jalr_sum = issue.opa + issue.offset;
    assign target   = (issue.branch_op == BR_JALR) ? {jalr_sum[`EXEC_XLEN-1:1], 1'b0}
                                                   : issue.pc + issue.offset;

    // Conditional branches write no register
    assign done_next.valid  = issue.valid && (!is_branch || is_link);
    assign done_next.result = is_link ? issue.pc + data_t'(4) : alu_result;
    assign done_next.dest   = issue.dest;

    assign resolve_next.valid  = issue.valid && is_branch;
    assign resolve_next.take   = take;
    assign resolve_next.target = target;

    always_ff @(posedge clock) begin
        done    <= done_next;
        resolve <= resolve_next;
        if (reset) begin
            done.valid    <= 1'b0;
            resolve.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/exec_pkg.sv
`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0] data_t;
    typedef logic [`EXEC_PREG_BITS-1:0] preg_t;

    // Integer operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // Branch kinds, BR_NONE for plain ALU work
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_JAL  = 4'd1,
        BR_JALR = 4'd2,
        BR_BEQ  = 4'd3,
        BR_BNE  = 4'd4,
        BR_BLT  = 4'd5,
        BR_BGE  = 4'd6,
        BR_BLTU = 4'd7,
        BR_BGEU = 4'd8
    } branch_op_e;

    // RV32M multiply kinds
    typedef enum logic [1:0] {
        MULT_MUL    = 2'd0,
        MULT_MULH   = 2'd1,
        MULT_MULHSU = 2'd2,
        MULT_MULHU  = 2'd3
    } mult_op_e;

    typedef struct packed {
        logic       valid;
        data_t      opa;
        data_t      opb;
        data_t      pc;
        data_t      offset;
        alu_op_e    alu_op;
        branch_op_e branch_op;
        preg_t      dest;
    } alu_packet_t;

    typedef struct packed {
        logic     valid;
        data_t    rs1_value;
        data_t    rs2_value;
        mult_op_e mult_op;
        preg_t    dest;
    } mult_packet_t;

    // One result on the common data bus
    typedef struct packed {
        logic  valid;
        data_t result;
        preg_t dest;
    } cdb_packet_t;

    typedef struct packed {
        logic  valid;
        logic  take;
        data_t target;
    } branch_packet_t;

endpackage

`default_nettype wire

//--- source/exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Machine word width
`define EXEC_XLEN 32

// Physical register index width
`define EXEC_PREG_BITS 6

// Multiplier pipeline depth, at least 2
`define EXEC_MULT_STAGES 4

`endif
